// ==== cache_pkg.sv ====
`default_nettype none

package cache_pkg;

    // line and set geometry
    localparam int LEN_LINE  = 5;
    localparam int LEN_INDEX = 6;
    // lru scheme below assumes exactly two ways
    localparam int NR_WAYS   = 2;

    localparam int NR_WORDS      = 1 << (LEN_LINE - 2);
    localparam int LEN_TAG       = 32 - LEN_INDEX - LEN_LINE;
    localparam int LEN_WORD_SEL  = LEN_LINE - 2;
    localparam int LEN_DATA_ADDR = LEN_INDEX + LEN_WORD_SEL;

    typedef logic [LEN_TAG-1:0] tag_t;
    typedef logic [31:0]        word_t;
    typedef logic [3:0]         strb_t;

endpackage

`default_nettype wire

// ==== bus_pkg.sv ====
`default_nettype none

package bus_pkg;

    // every burst moves one whole line
    localparam int BURST_LEN  = cache_pkg::NR_WORDS;
    localparam int BEAT_BYTES = 4;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        WRITEBACK,
        REFILL,
        DONE
    } ctrl_state_t;

endpackage

`default_nettype wire

// ==== cache_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_ram #(
    parameter type payload_t = cache_pkg::word_t,
    parameter int  ADDR_W    = cache_pkg::LEN_DATA_ADDR
) (
    input  wire                   clk,
    input  wire                   i_we,
    input  wire [ADDR_W-1:0]      i_waddr,
    input  wire payload_t         i_wdata,
    input  wire cache_pkg::strb_t i_wbe,
    input  wire [ADDR_W-1:0]      i_raddr,
    output payload_t              o_rdata
);
    import cache_pkg::*;

    localparam int W     = $bits(payload_t);
    localparam int DEPTH = 1 << ADDR_W;

    payload_t mem [DEPTH];
    strb_t    be;

    assign be = i_we ? i_wbe : '0;

    // byte lanes only matter for word payloads
    always_ff @(posedge clk) begin
        for (int i = 0; i < W; i++) begin
            if (be[i / 8]) begin
                mem[i_waddr][i] <= i_wdata[i];
            end
        end
        o_rdata <= mem[i_raddr];
    end

endmodule

`default_nettype wire

// ==== cache_meta.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_meta (
    input  wire                            clk,
    input  wire                            rst,
    input  wire [cache_pkg::LEN_INDEX-1:0] i_index,
    input  wire cache_pkg::tag_t           i_tag,
    input  wire cache_pkg::tag_t           i_rtag0,
    input  wire cache_pkg::tag_t           i_rtag1,
    input  wire                            i_touch,
    input  wire                            i_touch_way,
    input  wire                            i_set_dirty,
    input  wire                            i_fill,
    input  wire                            i_fill_way,
    input  wire                            i_clear_dirty,
    output logic                           o_hit,
    output logic                           o_hit_way,
    output logic                           o_victim_way,
    output logic                           o_victim_dirty
);
    import cache_pkg::*;

    localparam int NR_SETS = 1 << LEN_INDEX;

    logic [NR_WAYS-1:0] valid_q [NR_SETS];
    logic [NR_WAYS-1:0] dirty_q [NR_SETS];
    // set bit marks the way as not recently used
    logic [NR_WAYS-1:0] lru_q   [NR_SETS];
    logic [NR_WAYS-1:0] way_hit;

    assign way_hit[0] = valid_q[i_index][0] && (i_rtag0 == i_tag);
    assign way_hit[1] = valid_q[i_index][1] && (i_rtag1 == i_tag);

    assign o_hit          = |way_hit;
    assign o_hit_way      = way_hit[1];
    assign o_victim_way   = lru_q[i_index][1];
    assign o_victim_dirty = dirty_q[i_index][o_victim_way];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < NR_SETS; s++) begin
                valid_q[s] <= '0;
                dirty_q[s] <= '0;
                lru_q[s]   <= '0;
            end
        end else begin
            if (i_touch) begin
                lru_q[i_index][i_touch_way]  <= 1'b0;
                lru_q[i_index][!i_touch_way] <= 1'b1;
            end
            if (i_fill) begin
                valid_q[i_index][i_fill_way] <= 1'b1;
            end
            if (i_clear_dirty) begin
                dirty_q[i_index][i_fill_way] <= 1'b0;
            end
            // a store on the same edge wins over the clear
            if (i_set_dirty) begin
                dirty_q[i_index][i_touch_way] <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== cache_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_ctrl (
    input  wire                                 clk,
    input  wire                                 rst,
    input  wire                                 i_req,
    input  wire                                 i_we,
    input  wire [31:0]                          i_addr,
    input  wire cache_pkg::word_t               i_wdata,
    input  wire cache_pkg::strb_t               i_wstrb,
    output logic                                o_busy,
    output logic                                o_done,
    output cache_pkg::word_t                    o_rdata,
    output logic [31:0]                         o_araddr,
    output logic                                o_arvalid,
    input  wire                                 i_arready,
    input  wire cache_pkg::word_t               i_rdata,
    input  wire                                 i_rlast,
    input  wire                                 i_rvalid,
    output logic                                o_rready,
    output logic [31:0]                         o_awaddr,
    output logic                                o_awvalid,
    input  wire                                 i_awready,
    output cache_pkg::word_t                    o_wdata,
    output logic [bus_pkg::BEAT_BYTES-1:0]      o_wstrb,
    output logic                                o_wlast,
    output logic                                o_wvalid,
    input  wire                                 i_wready,
    input  wire                                 i_bvalid,
    output logic                                o_bready,
    input  wire                                 i_hit,
    input  wire                                 i_hit_way,
    input  wire                                 i_victim_way,
    input  wire                                 i_victim_dirty,
    input  wire cache_pkg::word_t               i_rdata_way0,
    input  wire cache_pkg::word_t               i_rdata_way1,
    input  wire cache_pkg::tag_t                i_victim_tag,
    output logic [cache_pkg::NR_WAYS-1:0]       o_tag_we,
    output logic [cache_pkg::NR_WAYS-1:0]       o_data_we,
    output cache_pkg::strb_t                    o_data_wbe,
    output logic [cache_pkg::LEN_DATA_ADDR-1:0] o_data_waddr,
    output cache_pkg::word_t                    o_data_wdata,
    output logic [cache_pkg::LEN_DATA_ADDR-1:0] o_data_raddr,
    output logic [cache_pkg::LEN_INDEX-1:0]     o_index,
    output logic                                o_touch,
    output logic                                o_touch_way,
    output logic                                o_set_dirty,
    output logic                                o_fill,
    output logic                                o_fill_way,
    output logic                                o_clear_dirty
);
    import cache_pkg::*;
    import bus_pkg::*;

    ctrl_state_t             state;
    logic                    lookup_q;
    logic [LEN_WORD_SEL-1:0] beat;
    logic [LEN_INDEX-1:0]    index_q;
    logic [LEN_WORD_SEL-1:0] req_word;
    logic                    we_q;
    word_t                   wdata_q;
    strb_t                   wstrb_q;
    logic                    way_q;
    word_t                   rdata_q;
    word_t                   hit_word;
    logic [LEN_WORD_SEL-1:0] rd_word;
    logic [NR_WAYS-1:0]      fill_sel;
    logic [NR_WAYS-1:0]      hit_sel;
    logic                    hit_fire;
    logic                    w_fire;
    logic                    r_fire;
    logic                    refill_end;
    logic                    wb_end;
    logic                    req_beat;

    function automatic word_t merge(word_t old_w, word_t new_w, strb_t be);
        word_t res;
        res = old_w;
        for (int b = 0; b < 4; b++) begin
            if (be[b]) begin
                res[8*b +: 8] = new_w[8*b +: 8];
            end
        end
        return res;
    endfunction

    assign o_busy  = (state != IDLE);
    assign o_done  = (state == DONE);
    assign o_rdata = rdata_q;
    assign o_index = index_q;
    assign o_wstrb = {BEAT_BYTES{1'b1}};
    assign o_wdata = way_q ? i_rdata_way1 : i_rdata_way0;

    assign hit_word   = i_hit_way ? i_rdata_way1 : i_rdata_way0;
    // tag ram outputs are valid on the second lookup cycle
    assign hit_fire   = (state == LOOKUP) && lookup_q && i_hit;
    assign w_fire     = o_wvalid && i_wready;
    assign r_fire     = (state == REFILL) && o_rready && i_rvalid;
    assign refill_end = r_fire && i_rlast;
    assign wb_end     = (state == WRITEBACK) && o_bready && i_bvalid;
    assign req_beat   = (beat == req_word);

    assign fill_sel = NR_WAYS'(1) << way_q;
    assign hit_sel  = NR_WAYS'(1) << i_hit_way;

    // metadata updates
    assign o_touch       = hit_fire || refill_end;
    assign o_touch_way   = hit_fire ? i_hit_way : way_q;
    assign o_set_dirty   = we_q && o_touch;
    assign o_fill        = refill_end;
    assign o_fill_way    = way_q;
    assign o_clear_dirty = wb_end;
    assign o_tag_we      = refill_end ? fill_sel : '0;

    // read one word ahead while the write burst streams
    assign rd_word      = beat + LEN_WORD_SEL'(w_fire);
    assign o_data_raddr = {index_q, (state == WRITEBACK) ? rd_word : req_word};

    always_comb begin
        o_data_we    = '0;
        o_data_wbe   = wstrb_q;
        o_data_waddr = {index_q, req_word};
        o_data_wdata = wdata_q;
        if (r_fire) begin
            o_data_we    = fill_sel;
            o_data_wbe   = '1;
            o_data_waddr = {index_q, beat};
            o_data_wdata = (we_q && req_beat) ? merge(i_rdata, wdata_q, wstrb_q) : i_rdata;
        end else if (hit_fire && we_q) begin
            o_data_we = hit_sel;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= IDLE;
            lookup_q  <= 1'b0;
            beat      <= '0;
            o_arvalid <= 1'b0;
            o_rready  <= 1'b0;
            o_awvalid <= 1'b0;
            o_wvalid  <= 1'b0;
            o_wlast   <= 1'b0;
            o_bready  <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (i_req) begin
                        state    <= LOOKUP;
                        lookup_q <= 1'b0;
                    end
                end
                LOOKUP: begin
                    lookup_q <= 1'b1;
                    if (lookup_q) begin
                        lookup_q <= 1'b0;
                        beat     <= '0;
                        if (i_hit) begin
                            state <= DONE;
                        end else if (i_victim_dirty) begin
                            o_awvalid <= 1'b1;
                            state     <= WRITEBACK;
                        end else begin
                            o_arvalid <= 1'b1;
                            state     <= REFILL;
                        end
                    end
                end
                WRITEBACK: begin
                    if (o_awvalid && i_awready) begin
                        o_awvalid <= 1'b0;
                        o_wvalid  <= 1'b1;
                    end
                    if (w_fire) begin
                        beat    <= beat + 1'b1;
                        o_wlast <= (beat == LEN_WORD_SEL'(BURST_LEN - 2));
                        if (o_wlast) begin
                            o_wvalid <= 1'b0;
                            o_wlast  <= 1'b0;
                            o_bready <= 1'b1;
                        end
                    end
                    if (wb_end) begin
                        o_bready  <= 1'b0;
                        o_arvalid <= 1'b1;
                        state     <= REFILL;
                    end
                end
                REFILL: begin
                    if (o_arvalid && i_arready) begin
                        o_arvalid <= 1'b0;
                        o_rready  <= 1'b1;
                    end
                    if (r_fire) begin
                        beat <= beat + 1'b1;
                        if (i_rlast) begin
                            o_rready <= 1'b0;
                            state    <= DONE;
                        end
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // request and burst payload
    always_ff @(posedge clk) begin
        if (state == IDLE && i_req) begin
            index_q  <= i_addr[LEN_LINE +: LEN_INDEX];
            req_word <= i_addr[2 +: LEN_WORD_SEL];
            we_q     <= i_we;
            wdata_q  <= i_wdata;
            wstrb_q  <= i_wstrb;
            o_araddr <= {i_addr[31:LEN_LINE], {LEN_LINE{1'b0}}};
        end
        if (state == LOOKUP && lookup_q) begin
            way_q    <= i_victim_way;
            o_awaddr <= {i_victim_tag, index_q, {LEN_LINE{1'b0}}};
            rdata_q  <= we_q ? merge(hit_word, wdata_q, wstrb_q) : hit_word;
        end
        if (r_fire && req_beat) begin
            rdata_q <= o_data_wdata;
        end
    end

endmodule

`default_nettype wire

// ==== d_cache.sv ====
`timescale 1ns/1ps
`default_nettype none

module d_cache (
    input  wire                            clk,
    input  wire                            rst,
    input  wire                            i_req,
    input  wire                            i_we,
    input  wire [31:0]                     i_addr,
    input  wire cache_pkg::word_t          i_wdata,
    input  wire cache_pkg::strb_t          i_wstrb,
    output logic                           o_busy,
    output logic                           o_done,
    output cache_pkg::word_t               o_rdata,
    output logic [31:0]                    o_araddr,
    output logic                           o_arvalid,
    input  wire                            i_arready,
    input  wire cache_pkg::word_t          i_rdata,
    input  wire                            i_rlast,
    input  wire                            i_rvalid,
    output logic                           o_rready,
    output logic [31:0]                    o_awaddr,
    output logic                           o_awvalid,
    input  wire                            i_awready,
    output cache_pkg::word_t               o_wdata,
    output logic [bus_pkg::BEAT_BYTES-1:0] o_wstrb,
    output logic                           o_wlast,
    output logic                           o_wvalid,
    input  wire                            i_wready,
    input  wire                            i_bvalid,
    output logic                           o_bready
);
    import cache_pkg::*;

    tag_t                     rtag [NR_WAYS];
    word_t                    rword [NR_WAYS];
    tag_t                     req_tag;
    tag_t                     victim_tag;
    logic [NR_WAYS-1:0]       tag_we;
    logic [NR_WAYS-1:0]       data_we;
    strb_t                    data_wbe;
    logic [LEN_DATA_ADDR-1:0] data_waddr;
    word_t                    data_wdata;
    logic [LEN_DATA_ADDR-1:0] data_raddr;
    logic [LEN_INDEX-1:0]     index;
    logic                     hit;
    logic                     hit_way;
    logic                     victim_way;
    logic                     victim_dirty;
    logic                     touch;
    logic                     touch_way;
    logic                     set_dirty;
    logic                     fill;
    logic                     fill_way;
    logic                     clear_dirty;

    // read address register holds the request line
    assign req_tag    = o_araddr[31 -: LEN_TAG];
    assign victim_tag = rtag[victim_way];

    for (genvar w = 0; w < NR_WAYS; w++) begin : g_way
        cache_ram #(
            .payload_t(tag_t),
            .ADDR_W   (LEN_INDEX)
        ) u_tag (
            .clk    (clk),
            .i_we   (tag_we[w]),
            .i_waddr(index),
            .i_wdata(req_tag),
            .i_wbe  ('1),
            .i_raddr(index),
            .o_rdata(rtag[w])
        );

        cache_ram #(
            .payload_t(word_t),
            .ADDR_W   (LEN_DATA_ADDR)
        ) u_data (
            .clk    (clk),
            .i_we   (data_we[w]),
            .i_waddr(data_waddr),
            .i_wdata(data_wdata),
            .i_wbe  (data_wbe),
            .i_raddr(data_raddr),
            .o_rdata(rword[w])
        );
    end

    cache_meta u_meta (
        .clk           (clk),
        .rst           (rst),
        .i_index       (index),
        .i_tag         (req_tag),
        .i_rtag0       (rtag[0]),
        .i_rtag1       (rtag[1]),
        .i_touch       (touch),
        .i_touch_way   (touch_way),
        .i_set_dirty   (set_dirty),
        .i_fill        (fill),
        .i_fill_way    (fill_way),
        .i_clear_dirty (clear_dirty),
        .o_hit         (hit),
        .o_hit_way     (hit_way),
        .o_victim_way  (victim_way),
        .o_victim_dirty(victim_dirty)
    );

    cache_ctrl u_ctrl (
        .clk           (clk),
        .rst           (rst),
        .i_req         (i_req),
        .i_we          (i_we),
        .i_addr        (i_addr),
        .i_wdata       (i_wdata),
        .i_wstrb       (i_wstrb),
        .o_busy        (o_busy),
        .o_done        (o_done),
        .o_rdata       (o_rdata),
        .o_araddr      (o_araddr),
        .o_arvalid     (o_arvalid),
        .i_arready     (i_arready),
        .i_rdata       (i_rdata),
        .i_rlast       (i_rlast),
        .i_rvalid      (i_rvalid),
        .o_rready      (o_rready),
        .o_awaddr      (o_awaddr),
        .o_awvalid     (o_awvalid),
        .i_awready     (i_awready),
        .o_wdata       (o_wdata),
        .o_wstrb       (o_wstrb),
        .o_wlast       (o_wlast),
        .o_wvalid      (o_wvalid),
        .i_wready      (i_wready),
        .i_bvalid      (i_bvalid),
        .o_bready      (o_bready),
        .i_hit         (hit),
        .i_hit_way     (hit_way),
        .i_victim_way  (victim_way),
        .i_victim_dirty(victim_dirty),
        .i_rdata_way0  (rword[0]),
        .i_rdata_way1  (rword[1]),
        .i_victim_tag  (victim_tag),
        .o_tag_we      (tag_we),
        .o_data_we     (data_we),
        .o_data_wbe    (data_wbe),
        .o_data_waddr  (data_waddr),
        .o_data_wdata  (data_wdata),
        .o_data_raddr  (data_raddr),
        .o_index       (index),
        .o_touch       (touch),
        .o_touch_way   (touch_way),
        .o_set_dirty   (set_dirty),
        .o_fill        (fill),
        .o_fill_way    (fill_way),
        .o_clear_dirty (clear_dirty)
    );

endmodule

`default_nettype wire

// ==== d_cache_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

module d_cache_sva (
    input wire                       clk,
    input wire                       rst,
    input wire                       o_arvalid,
    input wire                       i_arready,
    input wire                       o_awvalid,
    input wire                       i_awready,
    input wire                       o_wvalid,
    input wire                       o_done,
    input wire bus_pkg::ctrl_state_t i_state
);
    import bus_pkg::*;

    // address valids hold until accepted
    assert property (@(posedge clk) disable iff (rst) o_arvalid && !i_arready |=> o_arvalid)
        else $error("arvalid dropped before arready");

    assert property (@(posedge clk) disable iff (rst) o_awvalid && !i_awready |=> o_awvalid)
        else $error("awvalid dropped before awready");

    // write data only after the address handshake
    assert property (@(posedge clk) disable iff (rst) $rose(o_wvalid) |-> $past(o_awvalid && i_awready))
        else $error("wvalid rose before the aw handshake");

    assert property (@(posedge clk) disable iff (rst) o_wvalid |-> i_state == WRITEBACK)
        else $error("wvalid outside the write-back phase");

    assert property (@(posedge clk) disable iff (rst) o_done |=> !o_done)
        else $error("done lasted more than one cycle");

endmodule

bind cache_ctrl d_cache_sva u_sva (
    .clk      (clk),
    .rst      (rst),
    .o_arvalid(o_arvalid),
    .i_arready(i_arready),
    .o_awvalid(o_awvalid),
    .i_awready(i_awready),
    .o_wvalid (o_wvalid),
    .o_done   (o_done),
    .i_state  (state)
);

`default_nettype wire

// ==== tb_d_cache.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_d_cache;
    import cache_pkg::*;
    import bus_pkg::*;

    localparam int NR_COLS  = 7;
    localparam int MAX_VEC  = 64;
    localparam int MEM_WORDS = 4096;

    logic        clk;
    logic        rst;
    logic        i_req;
    logic        i_we;
    logic [31:0] i_addr;
    word_t       i_wdata;
    strb_t       i_wstrb;
    logic        o_busy;
    logic        o_done;
    word_t       o_rdata;
    logic [31:0] o_araddr;
    logic        o_arvalid;
    logic        i_arready;
    word_t       i_rdata;
    logic        i_rlast;
    logic        i_rvalid;
    logic        o_rready;
    logic [31:0] o_awaddr;
    logic        o_awvalid;
    logic        i_awready;
    word_t       o_wdata;
    logic [3:0]  o_wstrb;
    logic        o_wlast;
    logic        o_wvalid;
    logic        i_wready;
    logic        i_bvalid;
    logic        o_bready;

    logic [31:0] vec_mem [NR_COLS*MAX_VEC];
    word_t       mem [MEM_WORDS];
    int          errors;
    int          nvec;
    int          cycles;
    int          timeout_limit;
    int          rd_bursts;
    int          wr_bursts;

    // memory model state
    logic [31:0] r_addr;
    int          r_beat;
    logic        r_active;
    int          ar_wait;
    int          r_gap;
    logic [31:0] w_addr;
    int          w_beat;
    logic        w_active;
    logic        b_pending;
    int          aw_wait;
    int          w_wait;
    logic [11:0] r_idx;
    logic [11:0] w_idx;

    d_cache dut (
        .clk      (clk),
        .rst      (rst),
        .i_req    (i_req),
        .i_we     (i_we),
        .i_addr   (i_addr),
        .i_wdata  (i_wdata),
        .i_wstrb  (i_wstrb),
        .o_busy   (o_busy),
        .o_done   (o_done),
        .o_rdata  (o_rdata),
        .o_araddr (o_araddr),
        .o_arvalid(o_arvalid),
        .i_arready(i_arready),
        .i_rdata  (i_rdata),
        .i_rlast  (i_rlast),
        .i_rvalid (i_rvalid),
        .o_rready (o_rready),
        .o_awaddr (o_awaddr),
        .o_awvalid(o_awvalid),
        .i_awready(i_awready),
        .o_wdata  (o_wdata),
        .o_wstrb  (o_wstrb),
        .o_wlast  (o_wlast),
        .o_wvalid (o_wvalid),
        .i_wready (i_wready),
        .i_bvalid (i_bvalid),
        .o_bready (o_bready)
    );

    always #4 clk = ~clk;

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("Error: %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_range(input logic [31:0] addr);
        if (addr[31:14] != 18'd0) begin
            $display("Burst address %h lies outside the memory model", addr);
            errors++;
        end
    endtask

    // read side of the memory model
    always @(posedge clk) begin
        r_idx = r_addr[13:2] + 12'(r_beat);
        if (rst) begin
            i_arready <= 1'b0;
            i_rvalid  <= 1'b0;
            i_rlast   <= 1'b0;
            r_active  <= 1'b0;
        end else begin
            if (o_arvalid && i_arready) begin
                check_range(o_araddr);
                i_arready <= 1'b0;
                r_addr    <= o_araddr;
                r_beat    <= 0;
                r_active  <= 1'b1;
                r_gap     <= int'($urandom % 4);
                rd_bursts <= rd_bursts + 1;
            end else if (o_arvalid) begin
                if (ar_wait == 0) begin
                    i_arready <= 1'b1;
                end else begin
                    ar_wait <= ar_wait - 1;
                end
            end else begin
                ar_wait <= int'($urandom % 4);
            end
            if (i_rvalid && o_rready) begin
                i_rvalid <= 1'b0;
                i_rlast  <= 1'b0;
                r_gap    <= int'($urandom % 4);
                r_beat   <= r_beat + 1;
                if (i_rlast) begin
                    r_active <= 1'b0;
                end
            end else if (r_active && !i_rvalid) begin
                if (r_gap == 0) begin
                    i_rvalid <= 1'b1;
                    i_rdata  <= mem[r_idx];
                    i_rlast  <= (r_beat == BURST_LEN - 1);
                end else begin
                    r_gap <= r_gap - 1;
                end
            end
        end
    end

    // write side, records every beat into the array
    always @(posedge clk) begin
        w_idx = w_addr[13:2] + 12'(w_beat);
        if (rst) begin
            i_awready <= 1'b0;
            i_wready  <= 1'b0;
            i_bvalid  <= 1'b0;
            w_active  <= 1'b0;
            b_pending <= 1'b0;
        end else begin
            if (o_awvalid && i_awready) begin
                check_range(o_awaddr);
                i_awready <= 1'b0;
                w_addr    <= o_awaddr;
                w_beat    <= 0;
                w_active  <= 1'b1;
                w_wait    <= int'($urandom % 4);
                wr_bursts <= wr_bursts + 1;
            end else if (o_awvalid) begin
                if (aw_wait == 0) begin
                    i_awready <= 1'b1;
                end else begin
                    aw_wait <= aw_wait - 1;
                end
            end else begin
                aw_wait <= int'($urandom % 4);
            end
            if (o_wvalid && i_wready) begin
                mem[w_idx] <= o_wdata;
                check("o_wstrb", 32'(o_wstrb), 32'hF);
                check("o_wlast", 32'(o_wlast), 32'(w_beat == BURST_LEN - 1));
                w_beat   <= w_beat + 1;
                i_wready <= 1'b0;
                w_wait   <= int'($urandom % 4);
                if (o_wlast || w_beat == BURST_LEN - 1) begin
                    w_active  <= 1'b0;
                    b_pending <= 1'b1;
                end
            end else if (o_wvalid) begin
                if (!w_active) begin
                    $display("Write data was offered before the write address");
                    errors++;
                end
                if (w_wait == 0) begin
                    i_wready <= 1'b1;
                end else begin
                    w_wait <= w_wait - 1;
                end
            end
            if (i_bvalid && o_bready) begin
                i_bvalid <= 1'b0;
            end else if (b_pending && !i_bvalid) begin
                i_bvalid  <= 1'b1;
                b_pending <= 1'b0;
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= timeout_limit) begin
            $display("Timeout: requests did not finish within %0d cycles", timeout_limit);
            $display("*** FAILED ***");
            $finish;
        end
    end

    task automatic run_request(input int v);
        logic [31:0] op;
        logic [31:0] addr;
        logic [31:0] exp;
        int          lat;
        int          rd_start;
        int          wr_start;
        op   = vec_mem[v*NR_COLS];
        addr = vec_mem[v*NR_COLS+1];
        exp  = vec_mem[v*NR_COLS+4];
        rd_start = rd_bursts;
        wr_start = wr_bursts;
        @(posedge clk);
        i_req   <= 1'b1;
        i_we    <= op[0];
        i_addr  <= addr;
        i_wdata <= vec_mem[v*NR_COLS+2];
        i_wstrb <= vec_mem[v*NR_COLS+3][3:0];
        @(posedge clk);
        i_req <= 1'b0;
        lat = 0;
        // busy holds from the request edge through the done pulse
        do begin
            @(negedge clk);
            lat++;
            check("o_busy", 32'(o_busy), 32'd1);
        end while (!o_done);
        check("o_rdata", o_rdata, exp);
        check("read bursts", 32'(rd_bursts - rd_start), vec_mem[v*NR_COLS+5]);
        check("write bursts", 32'(wr_bursts - wr_start), vec_mem[v*NR_COLS+6]);
        // a request without bursts must be a hit
        if (vec_mem[v*NR_COLS+5] == 0 && vec_mem[v*NR_COLS+6] == 0) begin
            check("hit latency", 32'(lat), 32'd3);
        end
        @(negedge clk);
        check("o_busy", 32'(o_busy), 32'd0);
    endtask

    initial begin
        void'($urandom(32'h4065));
        clk       = 1'b0;
        rst       = 1'b1;
        i_req     = 1'b0;
        i_we      = 1'b0;
        i_addr    = '0;
        i_wdata   = '0;
        i_wstrb   = '0;
        i_arready = 1'b0;
        i_rdata   = '0;
        i_rlast   = 1'b0;
        i_rvalid  = 1'b0;
        i_awready = 1'b0;
        i_wready  = 1'b0;
        i_bvalid  = 1'b0;
        errors    = 0;
        cycles    = 0;
        rd_bursts = 0;
        wr_bursts = 0;
        ar_wait   = 0;
        aw_wait   = 0;
        r_addr    = '0;
        w_addr    = '0;
        r_beat    = 0;
        w_beat    = 0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = (32'(i) << 2) ^ 32'hA5A5_0000;
        end
        for (int i = 0; i < NR_COLS*MAX_VEC; i++) begin
            vec_mem[i] = '1;
        end
        $readmemh("d_cache_vectors.txt", vec_mem);
        nvec = 0;
        while (nvec < MAX_VEC && vec_mem[nvec*NR_COLS] != 32'hFFFF_FFFF) begin
            nvec++;
        end
        timeout_limit = nvec * 120;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        for (int v = 0; v < nvec; v++) begin
            run_request(v);
        end
        $display("Finished %0d vectors with %0d errors", nvec, errors);
        if (errors == 0 && nvec > 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== d_cache_vectors.txt ====
// columns: op (0 load, 1 store), addr, wdata, strb, expected rdata,
// read bursts, write bursts during the request
// load miss then hit, set 1
0 00000024 00000000 0 A5A50024 1 0
0 0000002C 00000000 0 A5A5002C 0 0
// store hit with partial strobes
1 00000028 11223344 3 A5A53344 0 0
0 00000028 00000000 0 A5A53344 0 0
// store miss, merge during refill, set 2
1 00000048 DEADBEEF C DEAD0048 1 0
0 00000048 00000000 0 DEAD0048 0 0
0 00000044 00000000 0 A5A50044 0 0
// lru victim choice in set 3
0 00000060 00000000 0 A5A50060 1 0
0 00000864 00000000 0 A5A50864 1 0
0 00000060 00000000 0 A5A50060 0 0
0 00001068 00000000 0 A5A51068 1 0
0 0000006C 00000000 0 A5A5006C 0 0
0 00000860 00000000 0 A5A50860 1 0
// dirty eviction in set 4
1 00000084 12345678 F 12345678 1 0
1 0000008C CAFEF00D 1 A5A5000D 0 0
0 00000880 00000000 0 A5A50880 1 0
0 00001080 00000000 0 A5A51080 1 1
0 00000084 00000000 0 12345678 1 0
0 0000008C 00000000 0 A5A5000D 0 0
0 00000080 00000000 0 A5A50080 0 0
// store miss with middle bytes, set 5
1 000008B4 00ABCD00 6 A5ABCDB4 1 0
0 000008B4 00000000 0 A5ABCDB4 0 0
0 000008BC 00000000 0 A5A508BC 0 0

// ==== vlog.f ====
cache_pkg.sv
bus_pkg.sv
cache_ram.sv
cache_meta.sv
cache_ctrl.sv
d_cache.sv
d_cache_sva.sv
tb_d_cache.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_d_cache
FLAGS     ?= --binary --timing --assert
BUILD     ?= obj_dir
FILELIST  ?= vlog.f

.PHONY: all build lint clean

all: build
	./$(BUILD)/V$(TOP) | tee /dev/stderr | grep -qF '*** PASSED ***'

build:
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD)

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD)
